// File: afi_read_output.sv
`timescale 1ns/10ps

module afi_read_output
	import rdp_pkg::*;
(
	input  logic                      pll_afi_clk,
	input  logic                      reset_n_afi_clk,
	input  group_bus_t                fifo_q_i,
	input  logic                      read_valid_i,
	input  logic                      afi_rdata_en_full_i,
	output afi_data_t                 afi_rdata_o,
	output afi_data_t                 phy_mux_read_fifo_q_o,
	output logic                      afi_rdata_valid_o,
	output logic [NUM_DQS_GROUPS-1:0] force_oct_off_o
);

	// **************************************************
	// Time-slot reordering
	// **************************************************

	// The FIFO output is ordered by group and then by time slot
	//   G1_T3 G1_T2 G1_T1 G1_T0 G0_T3 G0_T2 G0_T1 G0_T0
	// The AFI wants it ordered by time slot and then by group
	//   G1_T3 G0_T3 G1_T2 G0_T2 G1_T1 G0_T1 G1_T0 G0_T0
	// So slot t of group g lands at bit 8t + 4g of the AFI word
	always_comb
	begin
		afi_rdata_o = '0;
		for (int g = 0; g < NUM_DQS_GROUPS; g++)
		begin
			for (int t = 0; t < NUM_TIME_SLOTS; t++)
			begin
				afi_rdata_o[MEM_DQ_WIDTH*t + DQ_GROUP_WIDTH*g +: DQ_GROUP_WIDTH] =
					fifo_q_i[g][DQ_GROUP_WIDTH*t +: DQ_GROUP_WIDTH];
			end
		end
	end

	// The sequencer calibrates each group on its own and wants the group-major
	// layout, which is exactly what the FIFOs already deliver
	assign phy_mux_read_fifo_q_o = fifo_q_i;

	// **************************************************
	// Read valid
	// **************************************************

	// One more register lines the valid up with the word popped from the FIFOs
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
			afi_rdata_valid_o <= 1'b0;
		else
			afi_rdata_valid_o <= read_valid_i;
	end

	// **************************************************
	// OCT force-off window
	// **************************************************

	// Bit k of the full-enable history holds the value from k+1 edges ago
	logic [OCT_OFF_DELAY-1:0] en_full_hist;
	// With the current enable on bit 0 each tap k of this bus is k edges old
	logic [OCT_OFF_DELAY:0]   en_full_taps;
	// High while some read is inside the window where the pins must terminate
	logic                     oct_window;

	assign en_full_taps = {en_full_hist, afi_rdata_en_full_i};
	assign oct_window = |en_full_taps[OCT_OFF_DELAY:OCT_ON_DELAY];

	// Termination stays forced off except while read data is on the bus
	// A read sampled at edge N pulls the bits low from N+OCT_ON_DELAY
	// through N+OCT_OFF_DELAY
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			en_full_hist <= '0;
			force_oct_off_o <= '0;
		end
		else
		begin
			en_full_hist <= {en_full_hist[OCT_OFF_DELAY-2:0], afi_rdata_en_full_i};
			force_oct_off_o <= {NUM_DQS_GROUPS{~oct_window}};
		end
	end

endmodule

// File: rdp_pkg.sv
package rdp_pkg;

	// **************************************************
	// Datapath geometry
	// **************************************************

	// Number of read DQS groups on the memory side
	localparam int NUM_DQS_GROUPS = 2;
	// DQ bits captured by each DQS group
	localparam int DQ_GROUP_WIDTH = 4;
	localparam int MEM_DQ_WIDTH = NUM_DQS_GROUPS * DQ_GROUP_WIDTH;

	// Half rate means four memory beats land in every AFI cycle
	localparam int NUM_TIME_SLOTS = 4;
	localparam int AFI_DATA_WIDTH = MEM_DQ_WIDTH * NUM_TIME_SLOTS;
	localparam int GROUP_DATA_WIDTH = DQ_GROUP_WIDTH * NUM_TIME_SLOTS;

	// The resync FIFO depth is a power of two so the pointers wrap by themselves
	localparam int FIFO_DEPTH = 8;
	localparam int FIFO_ADDR_WIDTH = $clog2(FIFO_DEPTH);

	// **************************************************
	// Latency and termination timing
	// **************************************************

	// Length of the read-enable delay lines in AFI cycles
	localparam int MAX_READ_LATENCY = 12;
	localparam int LAT_CNT_WIDTH = 4;

	// Memory read latency counted in memory clock cycles
	localparam int MEM_T_RL = 8;
	// First and last delay tap of the window that keeps OCT enabled during a read
	localparam int OCT_ON_DELAY = (MEM_T_RL > 4) ? ((MEM_T_RL - 4) / 2) : 0;
	localparam int OCT_OFF_DELAY = (MEM_T_RL + 6) / 2;

	// One group's data for one AFI cycle with time slot t at bits 4t and up
	typedef logic [GROUP_DATA_WIDTH-1:0] group_word_t;
	// All groups side by side with group g at bits 16g and up
	typedef group_word_t [NUM_DQS_GROUPS-1:0] group_bus_t;
	// Read data word as seen on the AFI
	typedef logic [AFI_DATA_WIDTH-1:0] afi_data_t;

endpackage

// File: read_datapath.sv
`timescale 1ns/10ps

module read_datapath
	import rdp_pkg::*;
(
	input  logic                      pll_afi_clk,
	input  logic                      reset_n_afi_clk,
	input  logic [AFI_DATA_WIDTH-1:0] ddio_phy_dq_i,
	input  logic [NUM_DQS_GROUPS-1:0] ddio_dq_valid_i,
	input  logic [NUM_DQS_GROUPS-1:0] seq_read_fifo_reset_i,
	input  logic [LAT_CNT_WIDTH-1:0]  seq_read_latency_counter_i,
	input  logic                      afi_rdata_en_i,
	input  logic                      afi_rdata_en_full_i,
	output logic [AFI_DATA_WIDTH-1:0] afi_rdata_o,
	output logic                      afi_rdata_valid_o,
	output logic [AFI_DATA_WIDTH-1:0] phy_mux_read_fifo_q_o,
	output logic [NUM_DQS_GROUPS-1:0] force_oct_off_o
);

	// Pop strobe from the latency selector into the FIFOs
	logic       read_en;
	// The selector's valid runs one cycle ahead of the AFI valid
	logic       read_valid;
	// Popped words of all groups in group-major order
	group_bus_t fifo_q;

	// Captured data is buffered per DQS group
	read_resync_fifo u_resync_fifo (
		.pll_afi_clk           (pll_afi_clk),
		.reset_n_afi_clk       (reset_n_afi_clk),
		.ddio_phy_dq_i         (ddio_phy_dq_i),
		.ddio_dq_valid_i       (ddio_dq_valid_i),
		.seq_read_fifo_reset_i (seq_read_fifo_reset_i),
		.read_en_i             (read_en),
		.fifo_q_o              (fifo_q)
	);

	// One shared selector gives every group the same calibrated latency
	read_latency_tracker u_latency_tracker (
		.pll_afi_clk                (pll_afi_clk),
		.reset_n_afi_clk            (reset_n_afi_clk),
		.afi_rdata_en_i             (afi_rdata_en_i),
		.afi_rdata_en_full_i        (afi_rdata_en_full_i),
		.seq_read_latency_counter_i (seq_read_latency_counter_i),
		.read_en_o                  (read_en),
		.read_valid_o               (read_valid)
	);

	afi_read_output u_read_output (
		.pll_afi_clk           (pll_afi_clk),
		.reset_n_afi_clk       (reset_n_afi_clk),
		.fifo_q_i              (fifo_q),
		.read_valid_i          (read_valid),
		.afi_rdata_en_full_i   (afi_rdata_en_full_i),
		.afi_rdata_o           (afi_rdata_o),
		.phy_mux_read_fifo_q_o (phy_mux_read_fifo_q_o),
		.afi_rdata_valid_o     (afi_rdata_valid_o),
		.force_oct_off_o       (force_oct_off_o)
	);

endmodule

// File: read_latency_tracker.sv
`timescale 1ns/10ps

module read_latency_tracker
	import rdp_pkg::*;
(
	input  logic                     pll_afi_clk,
	input  logic                     reset_n_afi_clk,
	input  logic                     afi_rdata_en_i,
	input  logic                     afi_rdata_en_full_i,
	input  logic [LAT_CNT_WIDTH-1:0] seq_read_latency_counter_i,
	output logic                     read_en_o,
	output logic                     read_valid_o
);

	// **************************************************
	// Read-enable delay lines
	// **************************************************

	// Stage 0 holds the enable sampled at the last edge, stage k the one
	// sampled k edges before that
	// Several reads can sit in the lines at once and leave in order
	logic [MAX_READ_LATENCY-1:0] en_dly;
	logic [MAX_READ_LATENCY-1:0] en_full_dly;

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			en_dly <= '0;
			en_full_dly <= '0;
		end
		else
		begin
			en_dly <= {en_dly[MAX_READ_LATENCY-2:0], afi_rdata_en_i};
			en_full_dly <= {en_full_dly[MAX_READ_LATENCY-2:0], afi_rdata_en_full_i};
		end
	end

	// **************************************************
	// Latency tap select
	// **************************************************

	// The sequencer tunes L until the pop lines up with the captured data
	// The full enable times the FIFO pop, the plain enable times the valid
	// Both selects are registered, so for a read sampled at edge N the pop
	// request rises at N+L+1 and the FIFOs pop at N+L+2
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			read_en_o <= 1'b0;
			read_valid_o <= 1'b0;
		end
		else
		begin
			read_en_o <= en_full_dly[seq_read_latency_counter_i];
			read_valid_o <= en_dly[seq_read_latency_counter_i];
		end
	end

	// A latency beyond the delay line would select a tap that does not exist
	lat_in_range_a: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		seq_read_latency_counter_i < MAX_READ_LATENCY);

endmodule

// File: read_resync_fifo.sv
`timescale 1ns/10ps

module read_resync_fifo
	import rdp_pkg::*;
(
	input  logic                      pll_afi_clk,
	input  logic                      reset_n_afi_clk,
	input  group_bus_t                ddio_phy_dq_i,
	input  logic [NUM_DQS_GROUPS-1:0] ddio_dq_valid_i,
	input  logic [NUM_DQS_GROUPS-1:0] seq_read_fifo_reset_i,
	input  logic                      read_en_i,
	output group_bus_t                fifo_q_o
);

	// **************************************************
	// One resync FIFO per DQS group
	// **************************************************

	// Every group has its own pointers so the sequencer can realign one
	// group without touching the others during calibration
	// All groups are popped together by the shared latency selector
	for (genvar g = 0; g < NUM_DQS_GROUPS; g++)
	begin : grp
		group_word_t                mem [FIFO_DEPTH];
		logic [FIFO_ADDR_WIDTH-1:0] wr_ptr;
		logic [FIFO_ADDR_WIDTH-1:0] rd_ptr;
		// One extra bit so a full FIFO can be told apart from an empty one
		logic [FIFO_ADDR_WIDTH:0]   fill;
		logic                       push;
		logic                       pop;
		group_word_t                q_r;

		// A sequencer reset wins over a capture write or a pop in the same cycle
		assign push = ddio_dq_valid_i[g] & ~seq_read_fifo_reset_i[g];
		assign pop = read_en_i & ~seq_read_fifo_reset_i[g];

		// Captured data goes straight into the flop memory
		always_ff @(posedge pll_afi_clk)
		begin
			if (push)
				mem[wr_ptr] <= ddio_phy_dq_i[g];
		end

		always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
		begin
			if (!reset_n_afi_clk)
			begin
				wr_ptr <= '0;
				rd_ptr <= '0;
				fill <= '0;
			end
			else if (seq_read_fifo_reset_i[g])
			begin
				wr_ptr <= '0;
				rd_ptr <= '0;
				fill <= '0;
			end
			else
			begin
				if (push)
					wr_ptr <= wr_ptr + 1'b1;
				if (pop)
					rd_ptr <= rd_ptr + 1'b1;
				// Occupancy only moves when exactly one side is active
				if (push && !pop)
					fill <= fill + 1'b1;
				else if (pop && !push)
					fill <= fill - 1'b1;
			end
		end

		// The read port is registered so the word shows up one edge after the pop
		always_ff @(posedge pll_afi_clk)
		begin
			if (pop)
				q_r <= mem[rd_ptr];
		end

		assign fifo_q_o[g] = q_r;

		// The capture side has no back-pressure, so an overrun would lose data
		wr_not_full_a: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
			push |-> (fill != FIFO_DEPTH));

		// The latency selector must not pop a group before its word has arrived
		rd_not_empty_a: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
			pop |-> (fill != 0));
	end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the read datapath testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_read_datapath -f vlog.f -o sim_read_datapath
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_read_datapath > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -q "^TESTBENCH PASSED$" "$LOG"; then
	exit 0
fi
exit 1

// File: tb_read_vectors.svh
// **************************************************
// Stimulus table
// **************************************************

// Each row holds the test name, the capture words of group 0 and group 1,
// the latency L, the reads in a row and a FIFO reset before the capture
localparam int NUM_VECTORS = 5;

string       vec_name       [NUM_VECTORS] = '{"lat0_single", "lat3_single", "lat11_single",
                                              "lat3_burst", "lat5_fifo_reset"};
logic [15:0] vec_grp0_word  [NUM_VECTORS] = '{16'h3c5a, 16'h1234, 16'ha5f0,
                                              16'h7e81, 16'h2468};
logic [15:0] vec_grp1_word  [NUM_VECTORS] = '{16'h96e1, 16'hfedc, 16'h0f5a,
                                              16'hc3d2, 16'hace0};
logic [3:0]  vec_latency    [NUM_VECTORS] = '{4'd0, 4'd3, 4'd11, 4'd3, 4'd5};
int          vec_num_reads  [NUM_VECTORS] = '{1, 1, 1, 3, 1};
bit          vec_fifo_reset [NUM_VECTORS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1};

// Builds the AFI word one time slot at a time
// Each slot carries group 1 in its upper nibble and group 0 in its lower nibble
function automatic logic [31:0] interleave_groups(input logic [15:0] grp0,
	input logic [15:0] grp1);
	logic [31:0] word;
	word = '0;
	for (int t = 0; t < 4; t++)
	begin
		word[8*t +: 8] = {grp1[4*t +: 4], grp0[4*t +: 4]};
	end
	return word;
endfunction

// File: tb_read_datapath.sv
`timescale 1ns/10ps

module tb_read_datapath;

	// Edges counted from the enable edge N
	localparam int OCT_LOW_FIRST = 2;
	localparam int OCT_LOW_LAST = 7;
	// Upper bound on the edges to wait for the read valid pulses
	localparam int READ_TIMEOUT = 24;
	// Idle cycles that let both delay lines run empty between rows
	localparam int DRAIN_CYCLES = 14;

	logic        pll_afi_clk;
	logic        reset_n_afi_clk;
	logic [31:0] ddio_phy_dq_i;
	logic [1:0]  ddio_dq_valid_i;
	logic [1:0]  seq_read_fifo_reset_i;
	logic [3:0]  seq_read_latency_counter_i;
	logic        afi_rdata_en_i;
	logic        afi_rdata_en_full_i;
	logic [31:0] afi_rdata_o;
	logic        afi_rdata_valid_o;
	logic [31:0] phy_mux_read_fifo_q_o;
	logic [1:0]  force_oct_off_o;

	int          check_errors = 0;
	int          timeout_errors = 0;
	integer      seed = 32'h8b8f_4ba8;
	integer      rnd;
	// Expected words in the order the reads should return them
	logic [31:0] exp_afi_q [$];
	logic [31:0] exp_raw_q [$];

	`include "tb_read_vectors.svh"

	read_datapath dut (
		.pll_afi_clk                (pll_afi_clk),
		.reset_n_afi_clk            (reset_n_afi_clk),
		.ddio_phy_dq_i              (ddio_phy_dq_i),
		.ddio_dq_valid_i            (ddio_dq_valid_i),
		.seq_read_fifo_reset_i      (seq_read_fifo_reset_i),
		.seq_read_latency_counter_i (seq_read_latency_counter_i),
		.afi_rdata_en_i             (afi_rdata_en_i),
		.afi_rdata_en_full_i        (afi_rdata_en_full_i),
		.afi_rdata_o                (afi_rdata_o),
		.afi_rdata_valid_o          (afi_rdata_valid_o),
		.phy_mux_read_fifo_q_o      (phy_mux_read_fifo_q_o),
		.force_oct_off_o            (force_oct_off_o)
	);

	initial
	begin
		pll_afi_clk = 1'b0;
		forever #20 pll_afi_clk = ~pll_afi_clk;
	end

	// **************************************************
	// Stimulus tasks that start and end on a falling edge
	// **************************************************

	// One capture strobe for both groups at the next rising edge
	task automatic write_capture(input logic [15:0] grp0, input logic [15:0] grp1);
		ddio_phy_dq_i = {grp1, grp0};
		ddio_dq_valid_i = 2'b11;
		@(negedge pll_afi_clk);
		ddio_dq_valid_i = 2'b00;
	endtask

	task automatic pulse_fifo_reset();
		seq_read_fifo_reset_i = 2'b11;
		@(negedge pll_afi_clk);
		seq_read_fifo_reset_i = 2'b00;
	endtask

	// The first rising edge with the enables high is edge N
	task automatic issue_reads(input int reads);
		afi_rdata_en_i = 1'b1;
		afi_rdata_en_full_i = 1'b1;
		repeat (reads) @(negedge pll_afi_clk);
		afi_rdata_en_i = 1'b0;
		afi_rdata_en_full_i = 1'b0;
	endtask

	task automatic draw_random_word(output logic [15:0] word);
		rnd = $random(seed);
		word = rnd[15:0];
	endtask

	// **************************************************
	// Response checks
	// **************************************************

	// Outputs are sampled on the falling edge that follows edge N+k
	// Valid is expected at N+L+2 for every read and OCT is low from N+2 to N+7
	// plus one edge for every extra read in the burst
	task automatic check_read_window(input string name, input int lat, input int reads);
		int          k;
		int          seen;
		int          last_k;
		bit          in_slot;
		bit          in_oct;
		logic [1:0]  exp_oct;
		logic [31:0] exp_afi;
		logic [31:0] exp_raw;
		k = reads - 1;
		seen = 0;
		last_k = lat + 2 + reads;
		if (last_k < OCT_LOW_LAST + reads)
			last_k = OCT_LOW_LAST + reads;
		while ((seen < reads || k < last_k) && k < READ_TIMEOUT)
		begin
			@(negedge pll_afi_clk);
			k++;
			in_slot = (k >= lat + 2) && (k < lat + 2 + reads);
			assert (afi_rdata_valid_o == in_slot)
			else
			begin
				$display("CHECK FAILED: %s afi_rdata_valid_o at N+%0d expected %0b actual %0b",
					name, k, in_slot, afi_rdata_valid_o);
				check_errors++;
			end
			if (afi_rdata_valid_o && exp_afi_q.size() > 0)
			begin
				seen++;
				exp_afi = exp_afi_q.pop_front();
				exp_raw = exp_raw_q.pop_front();
				assert (afi_rdata_o == exp_afi)
				else
				begin
					$display("CHECK FAILED: %s afi_rdata_o expected %h actual %h",
						name, exp_afi, afi_rdata_o);
					check_errors++;
				end
				assert (phy_mux_read_fifo_q_o == exp_raw)
				else
				begin
					$display("CHECK FAILED: %s phy_mux_read_fifo_q_o expected %h actual %h",
						name, exp_raw, phy_mux_read_fifo_q_o);
					check_errors++;
				end
			end
			in_oct = (k >= OCT_LOW_FIRST) && (k <= OCT_LOW_LAST + reads - 1);
			exp_oct = in_oct ? 2'b00 : 2'b11;
			assert (force_oct_off_o == exp_oct)
			else
			begin
				$display("CHECK FAILED: %s force_oct_off_o at N+%0d expected %b actual %b",
					name, k, exp_oct, force_oct_off_o);
				check_errors++;
			end
		end
		if (seen < reads)
		begin
			$display("%s: only %0d of %0d read valid pulses arrived before the timeout",
				name, seen, reads);
			timeout_errors++;
		end
	endtask

	// Applies one table row from the capture writes to the drained delay lines
	task automatic run_vector(input int i);
		logic [15:0] grp0;
		logic [15:0] grp1;
		exp_afi_q.delete();
		exp_raw_q.delete();
		seq_read_latency_counter_i = vec_latency[i];
		// Stale words that the sequencer reset must throw away
		if (vec_fifo_reset[i])
		begin
			for (int s = 0; s < 2; s++)
			begin
				draw_random_word(grp0);
				draw_random_word(grp1);
				write_capture(grp0, grp1);
			end
			pulse_fifo_reset();
		end
		write_capture(vec_grp0_word[i], vec_grp1_word[i]);
		exp_afi_q.push_back(interleave_groups(vec_grp0_word[i], vec_grp1_word[i]));
		exp_raw_q.push_back({vec_grp1_word[i], vec_grp0_word[i]});
		// Further words of a burst are random
		for (int r = 1; r < vec_num_reads[i]; r++)
		begin
			draw_random_word(grp0);
			draw_random_word(grp1);
			write_capture(grp0, grp1);
			exp_afi_q.push_back(interleave_groups(grp0, grp1));
			exp_raw_q.push_back({grp1, grp0});
		end
		issue_reads(vec_num_reads[i]);
		check_read_window(vec_name[i], int'(vec_latency[i]), vec_num_reads[i]);
		repeat (DRAIN_CYCLES) @(negedge pll_afi_clk);
	endtask

	// **************************************************
	// Main sequence
	// **************************************************

	initial
	begin
		reset_n_afi_clk = 1'b0;
		ddio_phy_dq_i = '0;
		ddio_dq_valid_i = '0;
		seq_read_fifo_reset_i = '0;
		seq_read_latency_counter_i = '0;
		afi_rdata_en_i = 1'b0;
		afi_rdata_en_full_i = 1'b0;
		repeat (5) @(negedge pll_afi_clk);
		reset_n_afi_clk = 1'b1;
		// One rising edge after reset has set the idle OCT state
		@(negedge pll_afi_clk);
		assert (afi_rdata_valid_o == 1'b0)
		else
		begin
			$display("CHECK FAILED: reset afi_rdata_valid_o expected 0 actual %0b",
				afi_rdata_valid_o);
			check_errors++;
		end
		assert (force_oct_off_o == 2'b11)
		else
		begin
			$display("CHECK FAILED: reset force_oct_off_o expected 11 actual %b",
				force_oct_off_o);
			check_errors++;
		end
		for (int i = 0; i < NUM_VECTORS; i++)
		begin
			run_vector(i);
		end
		$display("Check errors: %0d, timeout errors: %0d", check_errors, timeout_errors);
		if (check_errors == 0 && timeout_errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+.
rdp_pkg.sv
read_resync_fifo.sv
read_latency_tracker.sv
afi_read_output.sv
read_datapath.sv
tb_read_datapath.sv
